//--- Makefile
# Verilator build for the system watchdog testbench

VERILATOR  ?= verilator
TOP        := systemWatchdogTb
FILELIST   := sim.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Exit status of the run is the pass or fail result
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- rtl/kickDecoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Watchdog kick decoder
// 68k byte write to $300001 becomes a one-cycle kick
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "wd_macros.svh"

module kickDecoder
(
	// Frame-rate clock
	input wire WDCLK,
	// Asynchronous clear, same meaning as a hardware kick
	input wire WDKICK,
	// Lower data strobe, active low
	input wire nLds,
	// High for read, low for write
	input wire rw,
	// Top address lines, both must be low
	input wire a23,
	input wire a22,
	// Address fields seen by the decoder
	input wire wdPkg::addrHi_t addrHi,
	input wire wdPkg::addrLo_t addrLo,
	// Power-on reset still held or synchronizing
	input wire rstHold,
	// One-cycle kick pulse
	output logic kick
);

	// Decode terms
	logic strobeOk;
	logic regionOk;
	logic hiOk;
	logic loOk;
	logic match;
	// Match was already present on the previous edge
	logic accessSeen;

	// Byte write on the lower lane only
	// An upper-strobe write or any read is ignored
	assign strobeOk = ~nLds & ~rw;

	// A23 and A22 low selects the lower 4 MB region
	assign regionOk = ~a23 & ~a22;

	// A21..A17 must read 11000
	// No A16 input on this chip, so $310001 aliases onto $300001
	// The real board mirrors the register across that bit
	assign hiOk = (addrHi == `WD_KICK_HI);

	// A12..A1 all clear, with A0 implied by the lower strobe
	assign loOk = (addrLo == '0);

	// Writes are locked out while power-on reset is in force
	assign match = strobeOk & regionOk & hiOk & loOk & ~rstHold;

	// Remember the match so a long bus cycle kicks once
	always_ff @(posedge WDCLK or posedge WDKICK)
	begin
		if (WDKICK)
			accessSeen <= 1'b0;
		else
			accessSeen <= match;
	end

	// First sampled cycle of a matching access only
	// Counter sees this at the same edge the match is sampled
	assign kick = match & ~accessSeen;

endmodule

`default_nettype wire

//--- rtl/resetSync.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Power-on reset synchronizer
// Asynchronous assert, clean release on WDCLK
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "wd_macros.svh"

module resetSync
(
	// Frame-rate clock
	input wire WDCLK,
	// Kick reset, forces the released state
	input wire WDKICK,
	// External power-on reset, active low
	input wire nRst,
	// High while reset is held or still synchronizing
	output logic rstHold
);

	// Release chain, fills with ones after nRst goes high
	logic [`WD_SYNC_STAGES-1:0] syncChain;

	// nRst low empties the chain at once
	// WDKICK puts it straight into the released state
	// Otherwise a one shifts in each edge
	always_ff @(posedge WDCLK or posedge WDKICK or negedge nRst)
	begin
		if (!nRst)
			syncChain <= '0;
		else if (WDKICK)
			syncChain <= '1;
		else
			syncChain <= {syncChain[`WD_SYNC_STAGES-2:0], 1'b1};
	end

	// Last stage set means fully released
	// With two stages this clears on the second edge after release
	assign rstHold = ~syncChain[`WD_SYNC_STAGES-1];

endmodule

`default_nettype wire

//--- rtl/systemWatchdog.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// System watchdog top level
// Kick decoder, reset synchronizer and frame counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module systemWatchdog
(
	// Frame-rate clock
	input wire WDCLK,
	// Asynchronous active-high reset, acts as a kick
	input wire WDKICK,
	// 68k bus levels sampled on WDCLK
	input wire nLds,
	input wire rw,
	input wire a23,
	input wire a22,
	input wire wdPkg::addrHi_t addrHi,
	input wire wdPkg::addrLo_t addrLo,
	// External power-on reset, active low
	input wire nRst,
	// CPU RESET instruction drive
	input wire cpuResetDrive,
	// System reset line, active low
	output wire nReset
);

	// Decoder to counter
	wire kick;
	// Synchronizer to decoder and counter
	wire rstHold;

	// Bus decode, locked out during power-on reset
	kickDecoder uKickDecoder
	(
		.WDCLK    (WDCLK),
		.WDKICK   (WDKICK),
		.nLds     (nLds),
		.rw       (rw),
		.a23      (a23),
		.a22      (a22),
		.addrHi   (addrHi),
		.addrLo   (addrLo),
		.rstHold  (rstHold),
		.kick     (kick)
	);

	// Power-on reset release
	resetSync uResetSync
	(
		.WDCLK    (WDCLK),
		.WDKICK   (WDKICK),
		.nRst     (nRst),
		.rstHold  (rstHold)
	);

	// Frame counter and reset line
	// count stays inside, the assertions pick it up by bind
	watchdogCounter uWatchdogCounter
	(
		.WDCLK          (WDCLK),
		.WDKICK         (WDKICK),
		.kick           (kick),
		.rstHold        (rstHold),
		.cpuResetDrive  (cpuResetDrive),
		.count          (),
		.nReset         (nReset)
	);

endmodule

`default_nettype wire

//--- rtl/watchdogCounter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Watchdog frame counter
// Kick clear, power-on preset, open-collector reset line
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "wd_macros.svh"

module watchdogCounter
(
	// Frame-rate clock
	input wire WDCLK,
	// Asynchronous clear
	input wire WDKICK,
	// One-cycle pulse from the decoder
	input wire kick,
	// Power-on reset held or synchronizing
	input wire rstHold,
	// CPU executing RESET, drives the line low
	input wire cpuResetDrive,
	// Counter value, reached only through bind
	output wdPkg::wdCount_t count,
	// System reset line, active low
	output logic nReset
);

	// Top bit of the counter
	logic wdHigh;
	// Watchdog side of the wired-AND, low when pulling down
	logic wdRelease;
	// CPU side of the wired-AND
	logic cpuRelease;

	// Priority is WDKICK, then power-on preset, then kick
	// Free-running otherwise, wraps modulo 16
	always_ff @(posedge WDCLK or posedge WDKICK)
	begin
		if (WDKICK)
			count <= '0;
		else if (rstHold)
			count <= wdPkg::wdCount_t'(`WD_PRESET);
		else if (kick)
			count <= '0;
		else
			count <= count + 1'b1;
	end

	assign wdHigh = count[`WD_WIDTH-1];

	// Counter top bit pulls the line low for 8 of every 16 frames
	// rstHold covers the part cycle before the preset lands
	// From the next edge on the preset top bit gives the same result
	assign wdRelease = ~wdHigh & ~rstHold;

	// RESET instruction drive is a separate open-collector source
	assign cpuRelease = ~cpuResetDrive;

	// Either driver low pulls the shared line low
	// Pull-up and rise time are not modelled
	assign nReset = wdRelease & cpuRelease;

endmodule

`default_nettype wire

//--- rtl/wdPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Watchdog shared types
// Bus address fields and counter value
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package wdPkg;

	`include "wd_macros.svh"

	// Upper address field A21..A17
	// Compared against WD_KICK_HI
	typedef logic [21:17] addrHi_t;

	// Lower address field A12..A1
	// All zero for a kick
	// A15..A13 are not wired to the decoder at all
	typedef logic [12:1] addrLo_t;

	// Watchdog frame counter
	typedef logic [`WD_WIDTH-1:0] wdCount_t;

endpackage

`default_nettype wire

//--- rtl/wd_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Watchdog constants
// Counter sizing, power-on preset, kick address, sync depth
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef WD_MACROS_SVH
`define WD_MACROS_SVH

// Frame counter width
// Top bit gives 8 frames released then 8 frames held
`define WD_WIDTH 4

// Loaded while power-on reset is held
// Top bit set so the reset line goes low straight away
`define WD_PRESET 8

// Required value of address bits 21..17 for $300001
// A21 and A20 set, A19..A17 clear
// A16 has no pin on the decoder so it never appears here
`define WD_KICK_HI 5'b11000

// Depth of the power-on reset release chain
// Must be at least 2
`define WD_SYNC_STAGES 2

`endif

//--- sim.f
+incdir+rtl
rtl/wdPkg.sv
rtl/kickDecoder.sv
rtl/resetSync.sv
rtl/watchdogCounter.sv
rtl/systemWatchdog.sv
verif/systemWatchdog_asserts.sv
verif/systemWatchdogTb.sv

//--- verif/systemWatchdogTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// System watchdog testbench
// Table of bus cycles against a cycle reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "wd_macros.svh"

module systemWatchdogTb;

	// Control field order is nLds, rw, a23, a22
	localparam logic [3:0] ctlIdle = 4'b1100;
	localparam logic [3:0] ctlWrite = 4'b0000;
	localparam logic [3:0] ctlRead = 4'b0100;
	localparam logic [3:0] ctlUpper = 4'b1000;
	localparam logic [3:0] ctlA23 = 4'b0010;
	localparam logic [3:0] ctlA22 = 4'b0001;

	// One table row held for hold cycles
	typedef struct {
		logic [3:0] ctl;
		wdPkg::addrHi_t addrHi;
		wdPkg::addrLo_t addrLo;
		logic nRst;
		logic cpuDrive;
		int hold;
		logic kickExp;
	} busRow_t;

	logic WDCLK;
	logic WDKICK;
	logic nLds;
	logic rw;
	logic a23;
	logic a22;
	wdPkg::addrHi_t addrHi;
	wdPkg::addrLo_t addrLo;
	logic nRst;
	logic cpuResetDrive;
	wire nReset;

	busRow_t rowTable[$];
	integer seed;

	// Reference model state
	wdPkg::wdCount_t mCount;
	logic mSeen;
	logic [`WD_SYNC_STAGES-1:0] mChain;

	systemWatchdog UUT
	(
		.WDCLK          (WDCLK),
		.WDKICK         (WDKICK),
		.nLds           (nLds),
		.rw             (rw),
		.a23            (a23),
		.a22            (a22),
		.addrHi         (addrHi),
		.addrLo         (addrLo),
		.nRst           (nRst),
		.cpuResetDrive  (cpuResetDrive),
		.nReset         (nReset)
	);

	// 40 ns frame clock
	initial
	begin
		WDCLK = 1'b0;
		forever #20 WDCLK = ~WDCLK;
	end

	task automatic abortRun;
		$display("Regression failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkReset(input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Fail at %0t: nReset is %b, model expects %b", $time, got, exp);
			abortRun();
		end
	endtask

	task automatic checkKick(input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Fail at %0t: kick is %b, table expects %b", $time, got, exp);
			abortRun();
		end
	endtask

	// Internal count peeked for diagnosis of nReset errors
	task automatic checkCount(input wdPkg::wdCount_t got, input wdPkg::wdCount_t exp);
		if (got !== exp)
		begin
			$display("Fail at %0t: count is %0d, model expects %0d", $time, got, exp);
			abortRun();
		end
	endtask

	function automatic busRow_t makeRow(input logic [3:0] ctl, input wdPkg::addrHi_t hi,
		input wdPkg::addrLo_t lo, input logic rstIn, input logic cpuIn, input int hold,
		input logic kickExp);
		busRow_t row;
		row.ctl = ctl;
		row.addrHi = hi;
		row.addrLo = lo;
		row.nRst = rstIn;
		row.cpuDrive = cpuIn;
		row.hold = hold;
		row.kickExp = kickExp;
		return row;
	endfunction

	// Drive on the falling edge and check before the model steps on the rising edge
	task automatic stepCycle(input busRow_t r, input logic kickExp);
		logic mHold;
		logic mMatch;
		logic mKick;
		@(negedge WDCLK);
		WDKICK = 1'b0;
		{nLds, rw, a23, a22} = r.ctl;
		addrHi = r.addrHi;
		addrLo = r.addrLo;
		nRst = r.nRst;
		cpuResetDrive = r.cpuDrive;
		// Power-on reset empties the release chain at once
		if (!r.nRst)
			mChain = '0;
		#1;
		mHold = ~mChain[`WD_SYNC_STAGES-1];
		mMatch = (r.ctl == ctlWrite) && (r.addrHi == `WD_KICK_HI) && (r.addrLo == '0)
			&& !mHold;
		mKick = mMatch && !mSeen;
		checkCount(UUT.uWatchdogCounter.count, mCount);
		checkKick(UUT.uKickDecoder.kick, kickExp);
		checkReset(nReset, ~mCount[`WD_WIDTH-1] & ~mHold & ~r.cpuDrive);
		@(posedge WDCLK);
		if (mHold)
			mCount = wdPkg::wdCount_t'(`WD_PRESET);
		else if (mKick)
			mCount = '0;
		else
			mCount = mCount + 1'b1;
		mSeen = mMatch;
		mChain = r.nRst ? {mChain[`WD_SYNC_STAGES-2:0], 1'b1} : '0;
		#1;
	endtask

	// Idle cycles until nReset reaches a level
	task automatic waitResetLevel(input busRow_t idle, input logic level, input int limit);
		int waited;
		waited = 0;
		while ((nReset !== level) && (waited < limit))
		begin
			stepCycle(idle, 1'b0);
			waited++;
		end
		if (nReset !== level)
		begin
			$display("Timeout: nReset never reached %b within %0d cycles", level, limit);
			abortRun();
		end
	endtask

	initial
	begin
		busRow_t idle;
		logic [31:0] r;
		logic [2:0] low3;
		WDKICK = 1'b1;
		{nLds, rw, a23, a22} = ctlIdle;
		addrHi = '0;
		addrLo = '0;
		nRst = 1'b1;
		cpuResetDrive = 1'b0;
		seed = 32'h15e3de52;
		mCount = '0;
		mSeen = 1'b0;
		mChain = '1;
		idle = makeRow(ctlIdle, 5'b00000, 12'h000, 1'b1, 1'b0, 1, 1'b0);

		// Free running and then kicks in the high and the low phase
		rowTable.push_back(makeRow(ctlIdle, 5'b00000, 12'h000, 1'b1, 1'b0, 32, 1'b0));
		rowTable.push_back(makeRow(ctlWrite, `WD_KICK_HI, 12'h000, 1'b1, 1'b0, 1, 1'b1));
		rowTable.push_back(makeRow(ctlIdle, 5'b00000, 12'h000, 1'b1, 1'b0, 12, 1'b0));
		rowTable.push_back(makeRow(ctlWrite, `WD_KICK_HI, 12'h000, 1'b1, 1'b0, 1, 1'b1));
		rowTable.push_back(makeRow(ctlIdle, 5'b00000, 12'h000, 1'b1, 1'b0, 10, 1'b0));
		// Near misses on strobe, direction, region and low address
		rowTable.push_back(makeRow(ctlRead, `WD_KICK_HI, 12'h000, 1'b1, 1'b0, 3, 1'b0));
		rowTable.push_back(makeRow(ctlUpper, `WD_KICK_HI, 12'h000, 1'b1, 1'b0, 3, 1'b0));
		rowTable.push_back(makeRow(ctlA23, `WD_KICK_HI, 12'h000, 1'b1, 1'b0, 3, 1'b0));
		rowTable.push_back(makeRow(ctlA22, `WD_KICK_HI, 12'h000, 1'b1, 1'b0, 3, 1'b0));
		rowTable.push_back(makeRow(ctlWrite, `WD_KICK_HI, 12'h001, 1'b1, 1'b0, 3, 1'b0));
		rowTable.push_back(makeRow(ctlIdle, 5'b00000, 12'h000, 1'b1, 1'b0, 6, 1'b0));
		// Long bus cycle with one kick only
		rowTable.push_back(makeRow(ctlWrite, `WD_KICK_HI, 12'h000, 1'b1, 1'b0, 20, 1'b1));
		rowTable.push_back(makeRow(ctlIdle, 5'b00000, 12'h000, 1'b1, 1'b0, 4, 1'b0));
		// Power-on reset with writes locked out until release completes
		rowTable.push_back(makeRow(ctlIdle, 5'b00000, 12'h000, 1'b0, 1'b0, 3, 1'b0));
		rowTable.push_back(makeRow(ctlWrite, `WD_KICK_HI, 12'h000, 1'b0, 1'b0, 3, 1'b0));
		rowTable.push_back(makeRow(ctlWrite, `WD_KICK_HI, 12'h000, 1'b1, 1'b0, 1, 1'b0));
		rowTable.push_back(makeRow(ctlIdle, 5'b00000, 12'h000, 1'b1, 1'b0, 14, 1'b0));
		// CPU RESET drive over a running counter
		rowTable.push_back(makeRow(ctlIdle, 5'b00000, 12'h000, 1'b1, 1'b1, 6, 1'b0));
		rowTable.push_back(makeRow(ctlWrite, `WD_KICK_HI, 12'h000, 1'b1, 1'b1, 1, 1'b1));
		rowTable.push_back(makeRow(ctlIdle, 5'b00000, 12'h000, 1'b1, 1'b0, 20, 1'b0));

		// Random near misses with A19..A17 nonzero
		for (int i = 0; i < 16; i++)
		begin
			r = $random(seed);
			low3 = r[2:0];
			if (low3 == 3'b000)
				low3 = 3'b101;
			rowTable.push_back(makeRow(ctlWrite, `WD_KICK_HI | {2'b00, low3}, 12'h000,
				1'b1, 1'b0, 1 + int'(r[5:4]), 1'b0));
			rowTable.push_back(makeRow(ctlIdle, 5'b00000, 12'h000,
				1'b1, 1'b0, 1 + int'(r[9:8]), 1'b0));
		end

		// WDKICK held over two rising edges
		repeat (2) @(posedge WDCLK);
		foreach (rowTable[i])
			for (int c = 0; c < rowTable[i].hold; c++)
				stepCycle(rowTable[i], (c == 0) ? rowTable[i].kickExp : 1'b0);

		// One more full swing of the line
		waitResetLevel(idle, 1'b0, 20);
		waitResetLevel(idle, 1'b1, 20);
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/systemWatchdog_asserts.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Watchdog assertions
// Kick pulse width, kick clear and power-on hold
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module systemWatchdog_asserts
(
	input wire WDCLK,
	input wire WDKICK,
	// Decoder output as seen by the counter
	input wire kick,
	input wire rstHold,
	input wire wdPkg::wdCount_t count,
	input wire nReset
);

	// A held bus cycle gives a single pulse
	assert property (@(posedge WDCLK) disable iff (WDKICK) kick |=> !kick)
	else
		$error("kick pulse lasted more than one cycle");

	// Kick clears the counter on the same edge
	assert property (@(posedge WDCLK) disable iff (WDKICK) kick |=> (count == '0))
	else
		$error("count not zero after a kick");

	// Line still low one edge after any held cycle
	// The preset top bit keeps it low once the hold clears
	assert property (@(posedge WDCLK) disable iff (WDKICK) rstHold |=> !nReset)
	else
		$error("nReset high right after the power-on hold");

endmodule

// Counter instance sees kick, rstHold, count and nReset together
bind watchdogCounter systemWatchdog_asserts uAsserts
(
	.WDCLK    (WDCLK),
	.WDKICK   (WDKICK),
	.kick     (kick),
	.rstHold  (rstHold),
	.count    (count),
	.nReset   (nReset)
);

`default_nettype wire
